/* vlog.f */
verilog/i2cPkg.sv
verilog/i2cByteSender.sv
verilog/commandDispatcher.sv
verilog/statusCollector.sv
verilog/i2cWriteTop.sv
dv/i2cBusMonitor.sv
dv/i2cWriteTb.sv

/* Makefile */
# Verilator flow for the I2C write subsystem.
# Any variable can be overridden on the command line, e.g. make sim TOP=i2cWriteTb

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TOP        ?= i2cWriteTb
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only when the testbench prints the pass message on a line of its own.
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/i2cWrite_golden.txt */
# write|blind <gap cycles, -1 for random 0..7> <channel> <byte hex>
# expect <channel> <frame index> <byte count> <bytes hex>; test <name> opens a test, check ends it
test singleByte
write 0 2 a5
expect 2 0 1 a5
check
test chainedFrame
write 0 1 3c
write 0 1 81
write 0 1 7e
expect 1 0 3 3c 81 7e
check
test gappedWrites
write 0 3 12
write 60 3 34
write 60 3 56
expect 3 0 1 12
expect 3 1 1 34
expect 3 2 1 56
check
test parallelChannels
write -1 0 01
write -1 1 11
write -1 2 21
write -1 3 31
write -1 0 02
write -1 1 12
write -1 2 22
write -1 3 32
expect 0 0 2 01 02
expect 1 1 2 11 12
expect 2 1 2 21 22
expect 3 3 2 31 32
check
test droppedCommands
write 0 0 5a
blind 0 0 ff
blind 0 5 11
blind 0 7 22
expect 0 1 1 5a
check

/* dv/i2cWriteTb.sv */
`timescale 1ns/10ps

module i2cWriteTb;

   localparam int channelCount = 4;
   localparam int logDepth     = 128;
   localparam int waitLimit    = 500;
   localparam int maxListed    = 6;

   logic                     clock4x;
   logic                     reset;
   logic                     cmdWrite;
   i2cPkg::writeCmd          cmd;
   logic [channelCount-1:0]  cmdFull;
   i2cPkg::channelStatus     status [channelCount];
   logic [channelCount-1:0]  scl;
   logic [channelCount-1:0]  sdaRelease;
   logic [channelCount-1:0]  sda;
   logic [logDepth-1:0][9:0] eventLog [channelCount];
   int                       eventCount [channelCount];

   // the expected bus events of each channel are kept in the monitor's encoding.
   logic [9:0] expectedLog [channelCount][logDepth];
   int         expectedCount [channelCount];
   int         checkedCount [channelCount];
   int         expectedBytes [channelCount];
   int         expectedFrames [channelCount];
   logic [7:0] listed [maxListed];

   int    testErrors;
   int    totalErrors;
   int    testsRun;
   int    testsFailed;
   string testName;

   i2cWriteTop
   #(
      .channelCount(channelCount)
   )
   i_dut
   (
      .clock4x   (clock4x),
      .reset     (reset),
      .cmdWrite  (cmdWrite),
      .cmd       (cmd),
      .cmdFull   (cmdFull),
      .status    (status),
      .scl       (scl),
      .sdaRelease(sdaRelease)
   );

   // the pull-up lifts a released line, so the bus level follows the release bit.
   assign sda = sdaRelease;

   for (genvar i = 0; i < channelCount; i++)
   begin : gMonitor
      i2cBusMonitor #(.logDepth(logDepth)) uMonitor
      (
         .clock4x   (clock4x),
         .scl       (scl[i]),
         .sda       (sda[i]),
         .eventLog  (eventLog[i]),
         .eventCount(eventCount[i])
      );
   end

   initial
   begin
      clock4x = 1'b0;
      forever #2 clock4x = ~clock4x;
   end

   task automatic expectEqual(input int actual, input int expected, input string what);
      assert (actual == expected)
      else
      begin
         $display("FAIL %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
         testErrors++;
      end
   endtask

   task automatic nextCycle();
      @(posedge clock4x);
      #1;
   endtask

   task automatic idleCycles(input int count);
      for (int i = 0; i < count; i++)
         nextCycle();
   endtask

   task automatic waitSlotFree(input int channel);
      int cycles;
      cycles = 0;
      if (channel < channelCount)
      begin
         while (cmdFull[channel] && (cycles < waitLimit))
         begin
            nextCycle();
            cycles++;
         end
         if (cmdFull[channel])
         begin
            $display("timeout: channel %0d never accepted another command", channel);
            testErrors++;
         end
      end
   endtask

   task automatic sendCommand(input int channel, input logic [7:0] value);
      cmd.channel = channel[2:0];
      cmd.data    = value;
      cmdWrite    = 1'b1;
      nextCycle();
      cmdWrite    = 1'b0;
   endtask

   task automatic appendEvent(input int channel, input logic [9:0] entry);
      if (expectedCount[channel] < logDepth)
      begin
         expectedLog[channel][expectedCount[channel]] = entry;
         expectedCount[channel]++;
      end
   endtask

   // a frame on the wire is a start, each byte with a released acknowledge bit, then a stop.
   task automatic addFrame(input int channel, input int byteCount);
      appendEvent(channel, {2'd1, 8'h00});
      for (int k = 0; k < byteCount; k++)
      begin
         appendEvent(channel, {2'd0, listed[k]});
         appendEvent(channel, {2'd3, 8'h01});
      end
      appendEvent(channel, {2'd2, 8'h00});
      expectedBytes[channel]  += byteCount;
      expectedFrames[channel] += 1;
   endtask

   task automatic waitAllIdle();
      int   cycles;
      logic busyNow;
      cycles  = 0;
      busyNow = 1'b1;
      while (busyNow && (cycles < waitLimit))
      begin
         busyNow = (cmdFull != '0);
         for (int i = 0; i < channelCount; i++)
            busyNow = busyNow | status[i].busy;
         if (busyNow)
         begin
            nextCycle();
            cycles++;
         end
      end
      if (busyNow)
      begin
         $display("timeout: the channels did not all return to idle");
         testErrors++;
      end
   endtask

   task automatic compareChannel(input int channel);
      expectEqual(eventCount[channel], expectedCount[channel],
                  $sformatf("channel %0d bus event count", channel));
      for (int k = checkedCount[channel];
           (k < expectedCount[channel]) && (k < eventCount[channel]); k++)
         expectEqual(int'(eventLog[channel][k]), int'(expectedLog[channel][k]),
                     $sformatf("channel %0d bus event %0d", channel, k));
      expectEqual(int'(status[channel].bytesSent), expectedBytes[channel],
                  $sformatf("channel %0d bytesSent", channel));
      expectEqual(int'(status[channel].framesDone), expectedFrames[channel],
                  $sformatf("channel %0d framesDone", channel));
      // later tests compare only the events that follow this point.
      checkedCount[channel]  = eventCount[channel];
      expectedCount[channel] = eventCount[channel];
   endtask

   task automatic finishTest();
      testsRun++;
      totalErrors += testErrors;
      if (testErrors != 0)
         testsFailed++;
      $display("test %s: %s, %0d errors", testName,
               (testErrors == 0) ? "passed" : "failed", testErrors);
      testErrors = 0;
   endtask

   task automatic checkResetState();
      testName = "resetState";
      for (int i = 0; i < channelCount; i++)
      begin
         expectEqual(scl[i], 1, $sformatf("channel %0d scl", i));
         expectEqual(sdaRelease[i], 1, $sformatf("channel %0d sdaRelease", i));
         expectEqual(cmdFull[i], 0, $sformatf("channel %0d cmdFull", i));
         expectEqual(int'(status[i].bytesSent), 0, $sformatf("channel %0d bytesSent", i));
         expectEqual(int'(status[i].framesDone), 0, $sformatf("channel %0d framesDone", i));
         expectEqual(status[i].busy, 0, $sformatf("channel %0d busy", i));
      end
      finishTest();
   endtask

   task automatic runGoldenFile();
      int         fd;
      string      line;
      string      kind;
      int         gap;
      int         channel;
      int         frameIndex;
      int         byteCount;
      logic [7:0] value;
      fd = $fopen("dv/i2cWrite_golden.txt", "r");
      if (fd == 0)
      begin
         $display("the golden file dv/i2cWrite_golden.txt could not be opened");
         totalErrors++;
         return;
      end
      while ($fgets(line, fd) != 0)
      begin
         kind = "";
         void'($sscanf(line, "%s", kind));
         if (kind == "test")
         begin
            void'($sscanf(line, "%s %s", kind, testName));
            testErrors = 0;
         end
         else if ((kind == "write") || (kind == "blind"))
         begin
            void'($sscanf(line, "%s %d %d %h", kind, gap, channel, value));
            if (gap < 0)
               gap = $urandom_range(7, 0);
            idleCycles(gap);
            // a blind write goes out even when the slot is full, so it gets dropped.
            if (kind == "write")
               waitSlotFree(channel);
            sendCommand(channel, value);
         end
         else if (kind == "expect")
         begin
            void'($sscanf(line, "%s %d %d %d %h %h %h %h %h %h", kind, channel, frameIndex,
                          byteCount, listed[0], listed[1], listed[2], listed[3], listed[4],
                          listed[5]));
            expectEqual(frameIndex, expectedFrames[channel],
                        $sformatf("golden frame index on channel %0d", channel));
            addFrame(channel, byteCount);
         end
         else if (kind == "check")
         begin
            waitAllIdle();
            for (int i = 0; i < channelCount; i++)
               compareChannel(i);
            finishTest();
         end
      end
      $fclose(fd);
   endtask

   initial
   begin
      void'($urandom(7969));
      reset       = 1'b1;
      cmdWrite    = 1'b0;
      cmd         = '0;
      testErrors  = 0;
      totalErrors = 0;
      testsRun    = 0;
      testsFailed = 0;
      for (int i = 0; i < channelCount; i++)
      begin
         expectedCount[i]  = 0;
         checkedCount[i]   = 0;
         expectedBytes[i]  = 0;
         expectedFrames[i] = 0;
      end
      repeat (3) @(posedge clock4x);
      #1;
      reset = 1'b0;
      checkResetState();
      runGoldenFile();
      $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
      if (totalErrors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* dv/i2cBusMonitor.sv */
`timescale 1ns/10ps

module i2cBusMonitor
#(
   parameter int logDepth = 128
)
(
   input  logic                     clock4x,
   input  logic                     scl,
   input  logic                     sda,
   output logic [logDepth-1:0][9:0] eventLog,
   output int                       eventCount
);

   // each log entry is a two-bit kind above an eight-bit value.
   localparam logic [1:0] kindByte  = 2'd0;
   localparam logic [1:0] kindStart = 2'd1;
   localparam logic [1:0] kindStop  = 2'd2;
   localparam logic [1:0] kindAck   = 2'd3;

   logic                     sclLast  = 1'b1;
   logic                     sdaLast  = 1'b1;
   logic [3:0]               bitCount = 4'd0;
   logic [7:0]               shiftIn  = 8'd0;
   logic [logDepth-1:0][9:0] entries  = '0;
   int                       count    = 0;

   assign eventLog   = entries;
   assign eventCount = count;

   task automatic record(input logic [1:0] kind, input logic [7:0] value);
      if (count < logDepth)
      begin
         entries[count] <= {kind, value};
         count          <= count + 1;
      end
   endtask

   // the lines only move on rising clock edges, so the falling edge sees them settled.
   always @(negedge clock4x)
   begin
      sclLast <= scl;
      sdaLast <= sda;
      if (scl && sclLast && sdaLast && !sda)
      begin
         bitCount <= 4'd0;
         record(kindStart, 8'h00);
      end
      else if (scl && sclLast && !sdaLast && sda)
      begin
         // the stop's own SCL pulse leaves a stray bit behind, which is dropped here.
         bitCount <= 4'd0;
         record(kindStop, 8'h00);
      end
      else if (scl && !sclLast)
      begin
         if (bitCount == 4'd8)
         begin
            bitCount <= 4'd0;
            record(kindAck, {7'd0, sda});
         end
         else
         begin
            shiftIn  <= {shiftIn[6:0], sda};
            bitCount <= bitCount + 4'd1;
            if (bitCount == 4'd7)
               record(kindByte, {shiftIn[6:0], sda});
         end
      end
   end

endmodule

/* verilog/i2cWriteTop.sv */
`timescale 1ns/10ps

module i2cWriteTop
#(
   parameter int channelCount = 4
)
(
   input  logic                    clock4x,
   input  logic                    reset,
   input  logic                    cmdWrite,
   input  i2cPkg::writeCmd         cmd,
   output logic [channelCount-1:0] cmdFull,
   output i2cPkg::channelStatus    status [channelCount],
   output logic [channelCount-1:0] scl,
   output logic [channelCount-1:0] sdaRelease
);

   logic [channelCount-1:0] load;
   logic [7:0]              data [channelCount];
   logic [channelCount-1:0] ack;
   logic [channelCount-1:0] idle;

   // the channel field of a command cannot address more than this.
   if ((channelCount < 1) || (channelCount > i2cPkg::maxChannels))
   begin : gBadChannelCount
      $error("channelCount must be between 1 and %0d", i2cPkg::maxChannels);
   end

   commandDispatcher
   #(
      .channelCount (channelCount)
   )
   uDispatcher
   (
      .clock4x (clock4x),
      .reset   (reset),
      .cmdWrite(cmdWrite),
      .cmd     (cmd),
      .ack     (ack),
      .load    (load),
      .data    (data),
      .cmdFull (cmdFull)
   );

   for (genvar i = 0; i < channelCount; i++)
   begin : gSender
      i2cByteSender uSender
      (
         .clock4x   (clock4x),
         .reset     (reset),
         .data      (data[i]),
         .load      (load[i]),
         .ack       (ack[i]),
         .idle      (idle[i]),
         .scl       (scl[i]),
         .sdaRelease(sdaRelease[i])
      );
   end

   statusCollector
   #(
      .channelCount (channelCount)
   )
   uCollector
   (
      .clock4x(clock4x),
      .reset  (reset),
      .ack    (ack),
      .idle   (idle),
      .status (status)
   );

endmodule

/* verilog/statusCollector.sv */
`timescale 1ns/10ps

module statusCollector
#(
   parameter int channelCount = 4
)
(
   input  logic                    clock4x,
   input  logic                    reset,
   input  logic [channelCount-1:0] ack,
   input  logic [channelCount-1:0] idle,
   output i2cPkg::channelStatus    status [channelCount]
);

   logic [channelCount-1:0] idleLast;
   logic [channelCount-1:0] frameEnd;

   // a frame is over when its sender goes back to idle.
   assign frameEnd = idle & ~idleLast;

   always_ff @(posedge clock4x)
   begin
      if (reset)
      begin
         // senders come out of reset idle, so no edge is seen then.
         idleLast <= '1;
         for (int i = 0; i < channelCount; i++)
         begin
            status[i] <= '0;
         end
      end
      else
      begin
         idleLast <= idle;
         for (int i = 0; i < channelCount; i++)
         begin
            // both counters stop at all ones rather than wrap.
            if (ack[i] && (status[i].bytesSent != '1))
               status[i].bytesSent <= status[i].bytesSent + 1'b1;
            if (frameEnd[i] && (status[i].framesDone != '1))
               status[i].framesDone <= status[i].framesDone + 1'b1;
            status[i].busy <= ~idle[i];
         end
      end
   end

endmodule

/* verilog/commandDispatcher.sv */
`timescale 1ns/10ps

module commandDispatcher
#(
   parameter int channelCount = 4
)
(
   input  logic                    clock4x,
   input  logic                    reset,
   input  logic                    cmdWrite,
   input  i2cPkg::writeCmd         cmd,
   input  logic [channelCount-1:0] ack,
   output logic [channelCount-1:0] load,
   output logic [7:0]              data [channelCount],
   output logic [channelCount-1:0] cmdFull
);

   logic [channelCount-1:0] occupied;
   logic [channelCount-1:0] slotWrite;

   // a channel number past channelCount matches no slot and the command is lost,
   // as is a write to an occupied slot.
   always_comb
   begin
      for (int i = 0; i < channelCount; i++)
      begin
         slotWrite[i] = cmdWrite && (int'(cmd.channel) == i) && !occupied[i];
      end
   end

   // ack can only arrive for an occupied slot, and an occupied slot is never
   // written, so the two never meet on the same edge.
   always_ff @(posedge clock4x)
   begin
      if (reset)
         occupied <= '0;
      else
      begin
         for (int i = 0; i < channelCount; i++)
         begin
            if (ack[i])
               occupied[i] <= 1'b0;
            else if (slotWrite[i])
               occupied[i] <= 1'b1;
         end
      end
   end

   // the data outputs are the slot registers themselves.
   always_ff @(posedge clock4x)
   begin
      for (int i = 0; i < channelCount; i++)
      begin
         if (slotWrite[i])
            data[i] <= cmd.data;
      end
   end

   assign load    = occupied;
   assign cmdFull = occupied;

endmodule

/* verilog/i2cByteSender.sv */
`timescale 1ns/10ps

module i2cByteSender
(
   input  logic       clock4x,
   input  logic       reset,
   input  logic [7:0] data,
   input  logic       load,
   output logic       ack,
   output logic       idle,
   output logic       scl,
   output logic       sdaRelease
);

   i2cPkg::senderPhase phase;
   logic [1:0]         quarter;
   logic [2:0]         bitIndex;
   logic [7:0]         shiftByte;
   logic               captureByte;

   // a byte is taken from idle, or at the last quarter of the acknowledge slot
   // when the dispatcher still has one waiting.
   assign captureByte = load &&
                        ((phase == i2cPkg::phIdle) ||
                         ((phase == i2cPkg::phAck) && (quarter == 2'd3)));

   // the sender keeps its own copy of the byte, so the dispatcher slot can refill while shifting.
   always_ff @(posedge clock4x)
   begin
      if (captureByte)
         shiftByte <= data;
   end

   always_ff @(posedge clock4x)
   begin
      if (reset)
      begin
         phase      <= i2cPkg::phIdle;
         quarter    <= 2'd0;
         bitIndex   <= 3'd7;
         ack        <= 1'b0;
         idle       <= 1'b1;
         scl        <= 1'b1;
         sdaRelease <= 1'b1;
      end
      else
      begin
         ack     <= captureByte;
         quarter <= quarter + 2'd1;
         case (phase)
            i2cPkg::phIdle:
            begin
               quarter <= 2'd0;
               if (load)
               begin
                  idle  <= 1'b0;
                  phase <= i2cPkg::phStart;
               end
            end

            // the start condition pulls SDA low while SCL is high, then SCL follows.
            i2cPkg::phStart:
            begin
               if (quarter == 2'd0)
                  sdaRelease <= 1'b0;
               else
               begin
                  scl      <= 1'b0;
                  quarter  <= 2'd0;
                  bitIndex <= 3'd7;
                  phase    <= i2cPkg::phData;
               end
            end

            // each bit is SDA set, SCL high, hold, SCL low.
            i2cPkg::phData:
            begin
               if (quarter == 2'd0)
                  sdaRelease <= shiftByte[bitIndex];
               else if (quarter == 2'd1)
                  scl <= 1'b1;
               else if (quarter == 2'd3)
               begin
                  scl <= 1'b0;
                  if (bitIndex == 3'd0)
                     phase <= i2cPkg::phAck;
                  else
                     bitIndex <= bitIndex - 3'd1;
               end
            end

            // ninth clock with SDA let go for the slave.
            i2cPkg::phAck:
            begin
               if (quarter == 2'd0)
                  sdaRelease <= 1'b1;
               else if (quarter == 2'd1)
                  scl <= 1'b1;
               else if (quarter == 2'd3)
               begin
                  scl <= 1'b0;
                  if (load)
                  begin
                     bitIndex <= 3'd7;
                     phase    <= i2cPkg::phData;
                  end
                  else
                     phase <= i2cPkg::phStop;
               end
            end

            // the stop condition drives SDA low, raises SCL, then lets SDA rise.
            i2cPkg::phStop:
            begin
               if (quarter == 2'd0)
                  sdaRelease <= 1'b0;
               else if (quarter == 2'd1)
                  scl <= 1'b1;
               else
               begin
                  sdaRelease <= 1'b1;
                  idle       <= 1'b1;
                  quarter    <= 2'd0;
                  phase      <= i2cPkg::phIdle;
               end
            end

            default:
            begin
               quarter <= 2'd0;
               phase   <= i2cPkg::phIdle;
            end
         endcase
      end
   end

endmodule

/* verilog/i2cPkg.sv */
package i2cPkg;

   // channelCount at the top level must not exceed this.
   localparam int maxChannels = 8;

   localparam int channelIdWidth = 3;

   // width of the per-channel byte and frame counters.
   localparam int countWidth = 16;

   // one byte command from the host carries its channel number.
   typedef struct packed
   {
      logic [channelIdWidth-1:0] channel;
      logic [7:0]                data;
   } writeCmd;

   // the per-channel status for the host is always valid.
   typedef struct packed
   {
      logic [countWidth-1:0] bytesSent;
      logic [countWidth-1:0] framesDone;
      logic                  busy;
   } channelStatus;

   // phases of one byte sender.
   typedef enum logic [2:0]
   {
      phIdle,
      phStart,
      phData,
      phAck,
      phStop
   } senderPhase;

endpackage
